//--- rtl/ahbPkg.sv
// AHB3-Lite protocol types
package ahbPkg;

  ////////////////////////////////////////////////////////////
  // Bus widths
  ////////////////////////////////////////////////////////////

  localparam int AddrWidth = 32;
  localparam int DataWidth = 32;

  typedef logic [AddrWidth-1:0] addrT;
  typedef logic [DataWidth-1:0] dataT;

  ////////////////////////////////////////////////////////////
  // Encodings
  ////////////////////////////////////////////////////////////

  // HTRANS
  typedef enum logic [1:0] {
    IDLE   = 2'b00,
    BUSY   = 2'b01,
    NONSEQ = 2'b10,
    SEQ    = 2'b11
  } transEnum;

  // HSIZE, only the sizes up to one bus word
  typedef enum logic [2:0] {
    BYTE = 3'b000,
    HALF = 3'b001,
    WORD = 3'b010
  } sizeEnum;

  // HRESP, AHB3-Lite has two codes only
  typedef enum logic {
    OKAY  = 1'b0,
    ERROR = 1'b1
  } respEnum;

  ////////////////////////////////////////////////////////////
  // Signal groups
  ////////////////////////////////////////////////////////////

  // One address phase, HSEL through HTRANS
  typedef struct packed {
    logic     sel;
    addrT     addr;
    logic     write;
    sizeEnum  size;
    transEnum trans;
  } addrPhaseStruct;

  // One response, HRDATA, HREADYOUT and HRESP
  typedef struct packed {
    dataT    rdata;
    logic    readyOut;
    respEnum resp;
  } respStruct;

  // Address phase driven on a layer with no transfer
  localparam addrPhaseStruct IdlePhase = '{
    sel:   1'b0,
    addr:  '0,
    write: 1'b0,
    size:  BYTE,
    trans: IDLE
  };

endpackage

//--- rtl/switchPkg.sv
// Switch internal types
package switchPkg;

  ////////////////////////////////////////////////////////////
  // Arbitration priority
  ////////////////////////////////////////////////////////////

  // Two bits, so four masters at most
  localparam int PrioWidth = 2;

  typedef logic [PrioWidth-1:0] prioT;

  ////////////////////////////////////////////////////////////
  // Master to slave request
  ////////////////////////////////////////////////////////////

  // Offered by each master port to every slave port
  typedef struct packed {
    logic                   valid;
    prioT                   prio;
    ahbPkg::addrPhaseStruct addrPhase;
  } requestStruct;

  ////////////////////////////////////////////////////////////
  // Master port FSM
  ////////////////////////////////////////////////////////////

  // IDLE also covers a normal data phase through a slave
  // PENDING holds a request that lost arbitration
  // ERR1 and ERR2 form the two-cycle error response
  typedef enum logic [1:0] {
    IDLE    = 2'b00,
    PENDING = 2'b01,
    ERR1    = 2'b10,
    ERR2    = 2'b11
  } mstStateEnum;

endpackage

//--- rtl/masterPort.sv
// AHB switch master port
`timescale 1ns/1ps

module masterPort #(
  parameter int           Slaves            = 2,
  parameter ahbPkg::addrT SlaveBase [Slaves] = '{default: '0},
  parameter ahbPkg::addrT SlaveMask [Slaves] = '{default: '0}
)
(
  input  logic                            HCLK,
  input  logic                            rst,
  input  ahbPkg::addrPhaseStruct          mstReq,
  input  switchPkg::prioT                 mstPrio,
  input  logic                            mstReady,
  output ahbPkg::respStruct               mstResp,
  output switchPkg::requestStruct         request,
  output logic [Slaves-1:0]               slaveSel,
  input  logic [Slaves-1:0]               grant,
  input  ahbPkg::respStruct [Slaves-1:0]  slvRespAll
);

  switchPkg::mstStateEnum state;
  switchPkg::mstStateEnum nextState;

  // Decode result of the live address phase
  logic [Slaves-1:0] liveSel;

  // Request held while waiting for a grant
  ahbPkg::addrPhaseStruct heldReq;
  switchPkg::prioT        heldPrio;
  logic [Slaves-1:0]      heldSel;

  // Slave that owns the current data phase
  logic [Slaves-1:0] dataSel;
  logic [Slaves-1:0] nextDataSel;

  logic acceptPhase;
  logic newXfer;
  logic pending;
  logic granted;

  ////////////////////////////////////////////////////////////
  // Address decode
  ////////////////////////////////////////////////////////////

  // Masked compare per slave
  // Lowest matching index wins so the result stays one-hot
  always_comb
  begin
    liveSel = '0;
    for (int s = Slaves - 1; s >= 0; s--)
    begin
      if ((mstReq.addr & SlaveMask[s]) == (SlaveBase[s] & SlaveMask[s]))
      begin
        liveSel    = '0;
        liveSel[s] = 1'b1;
      end
    end
  end

  // New address phases are only taken outside PENDING and ERR1
  assign acceptPhase = (state == switchPkg::IDLE) || (state == switchPkg::ERR2);
  assign pending     = (state == switchPkg::PENDING);

  // Valid address phase as seen by the master, NONSEQ or SEQ with HREADY
  assign newXfer = acceptPhase && mstReq.sel && mstReady &&
                   ((mstReq.trans == ahbPkg::NONSEQ) || (mstReq.trans == ahbPkg::SEQ));

  ////////////////////////////////////////////////////////////
  // Request towards the slave ports
  ////////////////////////////////////////////////////////////

  always_comb
  begin
    if (pending)
    begin
      // Replay the held transfer until granted
      request.valid     = 1'b1;
      request.prio      = heldPrio;
      request.addrPhase = heldReq;
      slaveSel          = heldSel;
    end
    else
    begin
      // A decode miss never reaches a slave
      request.valid     = newXfer && (|liveSel);
      request.prio      = mstPrio;
      request.addrPhase = mstReq;
      slaveSel          = newXfer ? liveSel : '0;
    end
  end

  // Only the selected slave can grant
  assign granted = |(grant & slaveSel);

  ////////////////////////////////////////////////////////////
  // FSM and data-phase owner
  ////////////////////////////////////////////////////////////

  always_comb
  begin
    nextState   = state;
    nextDataSel = dataSel;
    case (state)
      switchPkg::PENDING:
      begin
        // Data phase starts with the grant
        if (granted)
        begin
          nextState   = switchPkg::IDLE;
          nextDataSel = heldSel;
        end
      end
      switchPkg::ERR1:
      begin
        nextState = switchPkg::ERR2;
      end
      default:
      begin
        // IDLE and ERR2, a data phase may end here
        nextState = switchPkg::IDLE;
        if (mstReady)
        begin
          nextDataSel = '0;
          if (newXfer)
          begin
            if (~|liveSel)
              nextState = switchPkg::ERR1;
            else if (granted)
              nextDataSel = liveSel;
            else
              nextState = switchPkg::PENDING;
          end
        end
      end
    endcase
  end

  always_ff @(posedge HCLK)
  begin
    if (rst)
    begin
      state   <= switchPkg::IDLE;
      dataSel <= '0;
    end
    else
    begin
      state   <= nextState;
      dataSel <= nextDataSel;
    end
  end

  // Capture every accepted phase, used only after a lost arbitration
  always_ff @(posedge HCLK)
  begin
    if (newXfer)
    begin
      heldReq  <= mstReq;
      heldPrio <= mstPrio;
      heldSel  <= liveSel;
    end
  end

  ////////////////////////////////////////////////////////////
  // Response to the master
  ////////////////////////////////////////////////////////////

  always_comb
  begin
    mstResp.rdata    = '0;
    mstResp.readyOut = 1'b1;
    mstResp.resp     = ahbPkg::OKAY;
    case (state)
      switchPkg::PENDING:
      begin
        // Stretch the data phase while waiting
        mstResp.readyOut = 1'b0;
      end
      switchPkg::ERR1:
      begin
        mstResp.readyOut = 1'b0;
        mstResp.resp     = ahbPkg::ERROR;
      end
      switchPkg::ERR2:
      begin
        mstResp.resp = ahbPkg::ERROR;
      end
      default:
      begin
        // Route the owning slave back, okay when none
        for (int s = 0; s < Slaves; s++)
        begin
          if (dataSel[s])
            mstResp = slvRespAll[s];
        end
      end
    endcase
  end

endmodule

//--- rtl/slavePort.sv
// AHB switch slave port
`timescale 1ns/1ps

module slavePort #(
  parameter int Masters = 2
)
(
  input  logic                                   HCLK,
  input  logic                                   rst,
  input  switchPkg::requestStruct [Masters-1:0]  requests,
  input  logic [Masters-1:0]                     slaveSel,
  input  ahbPkg::dataT [Masters-1:0]             wdataAll,
  output logic [Masters-1:0]                     grant,
  output ahbPkg::addrPhaseStruct                 slvReq,
  output ahbPkg::dataT                           slvWdata,
  output logic                                   slvReady,
  input  ahbPkg::respStruct                      slvResp
);

  // Masters that want this slave now
  logic [Masters-1:0] candidate;

  // Arbitration result before the ready check
  logic [Masters-1:0] winner;
  switchPkg::prioT    bestPrio;
  logic               found;

  // Data-phase owner, one-hot, zero when the layer is free
  logic [Masters-1:0] ownerSel;
  logic               ownerValid;

  ////////////////////////////////////////////////////////////
  // Layer HREADY
  ////////////////////////////////////////////////////////////

  assign ownerValid = |ownerSel;

  // No open data phase means the layer is ready
  // Otherwise follow the slave's own HREADYOUT
  assign slvReady = ownerValid ? slvResp.readyOut : 1'b1;

  ////////////////////////////////////////////////////////////
  // Priority arbiter
  ////////////////////////////////////////////////////////////

  always_comb
  begin
    for (int m = 0; m < Masters; m++)
    begin
      candidate[m] = requests[m].valid && slaveSel[m];
    end
  end

  // Highest prio wins
  // Strict compare keeps the lowest index on a tie
  always_comb
  begin
    winner   = '0;
    bestPrio = '0;
    found    = 1'b0;
    for (int m = 0; m < Masters; m++)
    begin
      if (candidate[m] && (!found || (requests[m].prio > bestPrio)))
      begin
        winner    = '0;
        winner[m] = 1'b1;
        bestPrio  = requests[m].prio;
        found     = 1'b1;
      end
    end
  end

  // Nobody is granted while the slave stretches a data phase
  assign grant = slvReady ? winner : '0;

  ////////////////////////////////////////////////////////////
  // Address phase mux
  ////////////////////////////////////////////////////////////

  always_comb
  begin
    slvReq = ahbPkg::IdlePhase;
    for (int m = 0; m < Masters; m++)
    begin
      if (grant[m])
        slvReq = requests[m].addrPhase;
    end
  end

  ////////////////////////////////////////////////////////////
  // Data phase
  ////////////////////////////////////////////////////////////

  // Granted master owns the following data phase
  // Held while the slave inserts wait states
  always_ff @(posedge HCLK)
  begin
    if (rst)
      ownerSel <= '0;
    else if (slvReady)
      ownerSel <= grant;
  end

  // Write data follows the owner, not the current address phase
  always_comb
  begin
    slvWdata = '0;
    for (int m = 0; m < Masters; m++)
    begin
      if (ownerSel[m])
        slvWdata = wdataAll[m];
    end
  end

endmodule

//--- rtl/ahbSwitch.sv
// AHB3-Lite multi-layer switch
`timescale 1ns/1ps

module ahbSwitch #(
  parameter int           Masters            = 2,
  parameter int           Slaves             = 2,
  parameter ahbPkg::addrT SlaveBase [Slaves] = '{32'h0000_0000, 32'h1000_0000},
  parameter ahbPkg::addrT SlaveMask [Slaves] = '{32'hF000_0000, 32'hF000_0000}
)
(
  input  logic                                   HCLK,
  input  logic                                   rst,

  // Master side, AHB masters connect here
  input  ahbPkg::addrPhaseStruct [Masters-1:0]   mstReq,
  input  switchPkg::prioT [Masters-1:0]          mstPrio,
  input  ahbPkg::dataT [Masters-1:0]             mstWdata,
  input  logic [Masters-1:0]                     mstReady,
  output ahbPkg::respStruct [Masters-1:0]        mstResp,

  // Slave side, one layer per slave
  output ahbPkg::addrPhaseStruct [Slaves-1:0]    slvReq,
  output ahbPkg::dataT [Slaves-1:0]              slvWdata,
  output logic [Slaves-1:0]                      slvReady,
  input  ahbPkg::respStruct [Slaves-1:0]         slvResp
);

  // Requests, shared by all slave ports
  switchPkg::requestStruct [Masters-1:0] request;

  // Select and grant, in master order and in slave order
  logic [Masters-1:0][Slaves-1:0] mstSlaveSel;
  logic [Slaves-1:0][Masters-1:0] slvSlaveSel;
  logic [Slaves-1:0][Masters-1:0] slvGrant;
  logic [Masters-1:0][Slaves-1:0] mstGrant;

  ////////////////////////////////////////////////////////////
  // Master ports
  ////////////////////////////////////////////////////////////

  for (genvar m = 0; m < Masters; m++)
  begin : genMaster
    masterPort #(
      .Slaves    (Slaves),
      .SlaveBase (SlaveBase),
      .SlaveMask (SlaveMask)
    ) uMasterPort (
      .HCLK       (HCLK),
      .rst        (rst),
      .mstReq     (mstReq[m]),
      .mstPrio    (mstPrio[m]),
      .mstReady   (mstReady[m]),
      .mstResp    (mstResp[m]),
      .request    (request[m]),
      .slaveSel   (mstSlaveSel[m]),
      .grant      (mstGrant[m]),
      .slvRespAll (slvResp)
    );
  end

  ////////////////////////////////////////////////////////////
  // Crossbar transpose
  ////////////////////////////////////////////////////////////

  for (genvar s = 0; s < Slaves; s++)
  begin : genCross
    for (genvar m = 0; m < Masters; m++)
    begin : genCrossMaster
      assign slvSlaveSel[s][m] = mstSlaveSel[m][s];
      assign mstGrant[m][s]    = slvGrant[s][m];
    end
  end

  ////////////////////////////////////////////////////////////
  // Slave ports
  ////////////////////////////////////////////////////////////

  for (genvar s = 0; s < Slaves; s++)
  begin : genSlave
    slavePort #(
      .Masters (Masters)
    ) uSlavePort (
      .HCLK     (HCLK),
      .rst      (rst),
      .requests (request),
      .slaveSel (slvSlaveSel[s]),
      .wdataAll (mstWdata),
      .grant    (slvGrant[s]),
      .slvReq   (slvReq[s]),
      .slvWdata (slvWdata[s]),
      .slvReady (slvReady[s]),
      .slvResp  (slvResp[s])
    );
  end

endmodule

//--- tb/tbClock.sv
// Testbench clock and reset
`timescale 1ns/1ps

module tbClock #(
  parameter int Period      = 100,
  parameter int ResetCycles = 4
)
(
  output logic HCLK,
  output logic rst
);

  // Free running clock, starts low
  initial
  begin
    HCLK = 1'b0;
    forever #(Period / 2) HCLK = ~HCLK;
  end

  // Reset spans the first rising edges and drops on a falling edge
  initial
  begin
    rst = 1'b1;
    #(Period * ResetCycles);
    rst = 1'b0;
  end

endmodule

//--- tb/memSlave.sv
// Testbench AHB memory slave
`timescale 1ns/1ps

module memSlave #(
  parameter int Waits = 0,
  parameter int Words = 64
)
(
  input  logic                   HCLK,
  input  logic                   rst,
  input  ahbPkg::addrPhaseStruct req,
  input  logic                   ready,
  input  ahbPkg::dataT           wdata,
  output ahbPkg::respStruct      resp
);

  localparam int IdxWidth = $clog2(Words);

  ahbPkg::dataT mem [Words];

  // Data phase in progress
  logic                pendValid;
  logic                pendWrite;
  logic [IdxWidth-1:0] pendIdx;
  int                  count;

  logic accept;

  // Address phase taken only while the layer is ready
  assign accept = ready && req.sel &&
                  ((req.trans == ahbPkg::NONSEQ) || (req.trans == ahbPkg::SEQ));

  always_ff @(posedge HCLK)
  begin
    if (rst)
    begin
      pendValid <= 1'b0;
      pendWrite <= 1'b0;
      pendIdx   <= '0;
      count     <= 0;
    end
    else if (ready)
    begin
      // Write data belongs to the phase that ends here
      if (pendValid && pendWrite)
        mem[pendIdx] <= wdata;
      pendValid <= accept;
      pendWrite <= req.write;
      pendIdx   <= req.addr[IdxWidth+1:2];
      count     <= accept ? Waits : 0;
    end
    else if (count != 0)
    begin
      count <= count - 1;
    end
  end

  // Ready once the wait states have run out
  always_comb
  begin
    resp.readyOut = !pendValid || (count == 0);
    resp.resp     = ahbPkg::OKAY;
    resp.rdata    = (pendValid && !pendWrite) ? mem[pendIdx] : '0;
  end

endmodule

//--- tb/ahbSwitchTb.sv
// AHB switch testbench
`timescale 1ns/1ps

module ahbSwitchTb;

  localparam int Masters   = 2;
  localparam int Slaves    = 2;
  localparam int Period    = 100;
  localparam int MemWords  = 64;
  localparam int RandOps   = 24;
  // Random region holds 16 words per master
  localparam int RandWords = 32;

  localparam ahbPkg::addrT SlaveBase [Slaves] = '{32'h0000_0000, 32'h1000_0000};
  localparam ahbPkg::addrT SlaveMask [Slaves] = '{32'hF000_0000, 32'hF000_0000};
  localparam int           SlaveWaits [Slaves] = '{0, 2};
  localparam ahbPkg::addrT UnmappedAddr = 32'h2000_0000;

  // Watchdog budget
  localparam int NumTests          = 5;
  localparam int TransfersPerTest  = 40;
  localparam int CyclesPerTransfer = 10;
  localparam int TimeoutNs = NumTests * TransfersPerTest * CyclesPerTransfer * Period;

  logic HCLK;
  logic rst;

  ahbPkg::addrPhaseStruct [Masters-1:0] mstReq;
  switchPkg::prioT [Masters-1:0]        mstPrio;
  ahbPkg::dataT [Masters-1:0]           mstWdata;
  logic [Masters-1:0]                   mstReady;
  ahbPkg::respStruct [Masters-1:0]      mstResp;
  ahbPkg::addrPhaseStruct [Slaves-1:0]  slvReq;
  ahbPkg::dataT [Slaves-1:0]            slvWdata;
  logic [Slaves-1:0]                    slvReady;
  ahbPkg::respStruct [Slaves-1:0]       slvResp;

  integer seed;
  logic   watchSel;

  // Random stimulus where opData holds write data or the expected read data
  logic         opWrite [Masters][RandOps];
  ahbPkg::addrT opAddr [Masters][RandOps];
  ahbPkg::dataT opData [Masters][RandOps];
  ahbPkg::dataT refMem [Slaves][RandWords];
  logic         refValid [Slaves][RandWords];

  ////////////////////////////////////////////////////////////
  // DUT and environment
  ////////////////////////////////////////////////////////////

  tbClock #(.Period(Period), .ResetCycles(4)) i_clock (.HCLK(HCLK), .rst(rst));

  ahbSwitch #(
    .Masters   (Masters),
    .Slaves    (Slaves),
    .SlaveBase (SlaveBase),
    .SlaveMask (SlaveMask)
  ) i_dut (
    .HCLK     (HCLK),
    .rst      (rst),
    .mstReq   (mstReq),
    .mstPrio  (mstPrio),
    .mstWdata (mstWdata),
    .mstReady (mstReady),
    .mstResp  (mstResp),
    .slvReq   (slvReq),
    .slvWdata (slvWdata),
    .slvReady (slvReady),
    .slvResp  (slvResp)
  );

  // A single master sees its own HREADYOUT as HREADY
  for (genvar m = 0; m < Masters; m++)
  begin : genReady
    assign mstReady[m] = mstResp[m].readyOut;
  end

  for (genvar s = 0; s < Slaves; s++)
  begin : genMem
    memSlave #(.Waits(SlaveWaits[s]), .Words(MemWords)) i_mem (
      .HCLK  (HCLK),
      .rst   (rst),
      .req   (slvReq[s]),
      .ready (slvReady[s]),
      .wdata (slvWdata[s]),
      .resp  (slvResp[s])
    );
  end

  ////////////////////////////////////////////////////////////
  // Compare tasks
  ////////////////////////////////////////////////////////////

  task stopOnError(input string msg);
    $display("FAILED at %0d ns: %s", $time, msg);
    $display("Simulation failed");
    $fatal(1, "Stopped at the first error");
  endtask

  task automatic checkData(input ahbPkg::dataT got, input ahbPkg::dataT expected,
                           input string what);
    if (got !== expected)
      stopOnError($sformatf("%s data expected %h got %h", what, expected, got));
  endtask

  task automatic checkResp(input ahbPkg::respEnum got, input ahbPkg::respEnum expected,
                           input string what);
    if (got !== expected)
      stopOnError($sformatf("%s resp expected %s got %b", what, expected.name(), got));
  endtask

  task automatic expectFlag(input logic got, input logic expected, input string what);
    if (got !== expected)
      stopOnError($sformatf("%s expected %b got %b", what, expected, got));
  endtask

  task automatic expectTrans(input ahbPkg::transEnum got, input ahbPkg::transEnum expected,
                             input string what);
    if (got !== expected)
      stopOnError($sformatf("%s trans expected %s got %b", what, expected.name(), got));
  endtask

  task automatic expectWaits(input int got, input int expected, input string what);
    if (got != expected)
      stopOnError($sformatf("%s wait cycles expected %0d got %0d", what, expected, got));
  endtask

  ////////////////////////////////////////////////////////////
  // Bus master tasks
  ////////////////////////////////////////////////////////////

  // Present one NONSEQ word phase and hold it until a cycle with HREADY high
  task automatic driveAddr(input int m, input logic write, input ahbPkg::addrT addr);
    ahbPkg::addrPhaseStruct phase;
    phase.sel   = 1'b1;
    phase.addr  = addr;
    phase.write = write;
    phase.size  = ahbPkg::WORD;
    phase.trans = ahbPkg::NONSEQ;
    @(negedge HCLK);
    mstReq[m] = phase;
    while (!mstResp[m].readyOut)
      @(negedge HCLK);
  endtask

  // Full transfer that counts the low HREADYOUT cycles of the data phase
  task automatic runXfer(input int m, input logic write, input ahbPkg::addrT addr,
                         input ahbPkg::dataT wdata, output ahbPkg::dataT rdata,
                         output ahbPkg::respEnum resp, output int waits);
    driveAddr(m, write, addr);
    @(negedge HCLK);
    mstReq[m] = ahbPkg::IdlePhase;
    if (write)
      mstWdata[m] = wdata;
    waits = 0;
    while (!mstResp[m].readyOut)
    begin
      waits++;
      @(negedge HCLK);
    end
    rdata = mstResp[m].rdata;
    resp  = mstResp[m].resp;
  endtask

  ////////////////////////////////////////////////////////////
  // Directed tests
  ////////////////////////////////////////////////////////////

  task resetState;
    for (int m = 0; m < Masters; m++)
    begin
      expectFlag(mstResp[m].readyOut, 1'b1, "reset master ready");
      checkResp(mstResp[m].resp, ahbPkg::OKAY, "reset master");
    end
    for (int s = 0; s < Slaves; s++)
    begin
      expectFlag(slvReq[s].sel, 1'b0, "reset slave sel");
      expectTrans(slvReq[s].trans, ahbPkg::IDLE, "reset slave");
      expectFlag(slvReady[s], 1'b1, "reset slave ready");
    end
  endtask

  // Every master through every slave
  task writeReadAll;
    ahbPkg::addrT    addr;
    ahbPkg::dataT    data;
    ahbPkg::dataT    rdata;
    ahbPkg::respEnum resp;
    int              waits;
    for (int m = 0; m < Masters; m++)
    begin
      for (int s = 0; s < Slaves; s++)
      begin
        addr = SlaveBase[s] + 32'h80 + m * 4;
        data = 32'hA500_0000 | (m << 8) | s;
        runXfer(m, 1'b1, addr, data, rdata, resp, waits);
        checkResp(resp, ahbPkg::OKAY, "write");
        expectWaits(waits, SlaveWaits[s], "write");
        runXfer(m, 1'b0, addr, '0, rdata, resp, waits);
        checkResp(resp, ahbPkg::OKAY, "read");
        checkData(rdata, data, "read");
      end
    end
  endtask

  // Two cycle ERROR response with no slave selected
  task unmappedAccess;
    watchSel = 1'b1;
    driveAddr(0, 1'b0, UnmappedAddr);
    @(negedge HCLK);
    mstReq[0] = ahbPkg::IdlePhase;
    expectFlag(mstResp[0].readyOut, 1'b0, "first error cycle ready");
    checkResp(mstResp[0].resp, ahbPkg::ERROR, "first error cycle");
    @(negedge HCLK);
    expectFlag(mstResp[0].readyOut, 1'b1, "second error cycle ready");
    checkResp(mstResp[0].resp, ahbPkg::ERROR, "second error cycle");
    watchSel = 1'b0;
  endtask

  // Master 0 wins while master 1 waits one cycle and writes last
  task sameAddressRace;
    ahbPkg::dataT    rdata0;
    ahbPkg::dataT    rdata1;
    ahbPkg::respEnum resp0;
    ahbPkg::respEnum resp1;
    int              waits0;
    int              waits1;
    fork
      runXfer(0, 1'b1, 32'h0000_00C0, 32'h1111_0000, rdata0, resp0, waits0);
      runXfer(1, 1'b1, 32'h0000_00C0, 32'h2222_0001, rdata1, resp1, waits1);
    join
    checkResp(resp0, ahbPkg::OKAY, "race master 0");
    checkResp(resp1, ahbPkg::OKAY, "race master 1");
    expectWaits(waits0, 0, "race master 0");
    expectWaits(waits1, 1, "race master 1");
    runXfer(0, 1'b0, 32'h0000_00C0, '0, rdata0, resp0, waits0);
    checkData(rdata0, 32'h2222_0001, "race readback");
  endtask

  // Separate layers run side by side with only the slave waits
  task parallelLayers;
    ahbPkg::dataT    rdata0;
    ahbPkg::dataT    rdata1;
    ahbPkg::respEnum resp0;
    ahbPkg::respEnum resp1;
    int              waits0;
    int              waits1;
    fork
      runXfer(0, 1'b1, 32'h0000_00A0, 32'h3333_0000, rdata0, resp0, waits0);
      runXfer(1, 1'b1, 32'h1000_00A4, 32'h4444_0001, rdata1, resp1, waits1);
    join
    expectWaits(waits0, SlaveWaits[0], "parallel write master 0");
    expectWaits(waits1, SlaveWaits[1], "parallel write master 1");
    fork
      runXfer(0, 1'b0, 32'h0000_00A0, '0, rdata0, resp0, waits0);
      runXfer(1, 1'b0, 32'h1000_00A4, '0, rdata1, resp1, waits1);
    join
    expectWaits(waits0, SlaveWaits[0], "parallel read master 0");
    expectWaits(waits1, SlaveWaits[1], "parallel read master 1");
    checkResp(resp0, ahbPkg::OKAY, "parallel read master 0");
    checkResp(resp1, ahbPkg::OKAY, "parallel read master 1");
    checkData(rdata0, 32'h3333_0000, "parallel read master 0");
    checkData(rdata1, 32'h4444_0001, "parallel read master 1");
  endtask

  task automatic replayOps(input int m);
    ahbPkg::dataT    rdata;
    ahbPkg::respEnum resp;
    int              waits;
    for (int i = 0; i < RandOps; i++)
    begin
      runXfer(m, opWrite[m][i], opAddr[m][i], opData[m][i], rdata, resp, waits);
      checkResp(resp, ahbPkg::OKAY, $sformatf("random op %0d master %0d", i, m));
      if (!opWrite[m][i])
        checkData(rdata, opData[m][i], $sformatf("random op %0d master %0d", i, m));
    end
  endtask

  // Each master owns half of the words so the reference order is fixed
  task randomTraffic;
    int slave;
    int word;
    for (int s = 0; s < Slaves; s++)
      for (int w = 0; w < RandWords; w++)
        refValid[s][w] = 1'b0;
    for (int m = 0; m < Masters; m++)
    begin
      for (int i = 0; i < RandOps; i++)
      begin
        slave = $random(seed) & 1;
        word  = m * 16 + ($random(seed) & 15);
        // Unwritten words are written first
        opWrite[m][i] = (($random(seed) & 1) == 1) || !refValid[slave][word];
        opAddr[m][i]  = SlaveBase[slave] + word * 4;
        if (opWrite[m][i])
        begin
          opData[m][i]          = $random(seed);
          refMem[slave][word]   = opData[m][i];
          refValid[slave][word] = 1'b1;
        end
        else
        begin
          opData[m][i] = refMem[slave][word];
        end
      end
    end
    fork
      replayOps(0);
      replayOps(1);
    join
  endtask

  ////////////////////////////////////////////////////////////
  // Sequence, monitor and watchdog
  ////////////////////////////////////////////////////////////

  initial
  begin
    seed     = 32'h735a;
    watchSel = 1'b0;
    for (int m = 0; m < Masters; m++)
    begin
      mstReq[m]   = ahbPkg::IdlePhase;
      mstWdata[m] = '0;
    end
    // Master 0 has the higher priority
    mstPrio[0] = 2'd1;
    mstPrio[1] = 2'd0;
    @(negedge rst);
    resetState();
    writeReadAll();
    unmappedAccess();
    sameAddressRace();
    parallelLayers();
    randomTraffic();
    @(negedge HCLK);
    $display("Simulation completed successfully");
    $finish;
  end

  // No layer may see a select during an unmapped access
  always @(posedge HCLK)
  begin
    if (watchSel)
      for (int s = 0; s < Slaves; s++)
        if (slvReq[s].sel)
          stopOnError($sformatf("slave %0d selected during an unmapped access", s));
  end

  initial
  begin
    #(TimeoutNs);
    $display("Timeout: the tests did not finish within %0d ns", TimeoutNs);
    $display("Simulation failed");
    $fatal(1, "Watchdog expired");
  end

endmodule

//--- verilog.f
rtl/ahbPkg.sv
rtl/switchPkg.sv
rtl/masterPort.sv
rtl/slavePort.sv
rtl/ahbSwitch.sv
tb/tbClock.sv
tb/memSlave.sv
tb/ahbSwitchTb.sv

//--- Bender.yml
package:
  name: ahb_switch

sources:
  # Packages first, then the ports, then the top level
  - rtl/ahbPkg.sv
  - rtl/switchPkg.sv
  - rtl/masterPort.sv
  - rtl/slavePort.sv
  - rtl/ahbSwitch.sv

  # Testbench with top module ahbSwitchTb
  - target: test
    files:
      - tb/tbClock.sv
      - tb/memSlave.sv
      - tb/ahbSwitchTb.sv
